// File: rtl/ising_pkg.sv
// ----------------------------------------
// Shared sizes, register map, weight coding
// and noise LFSR constants.
// ----------------------------------------
`default_nettype none

package ising_pkg;

    localparam int N           = 3;
    // the number of weight levels must be odd so that zero has its own bit.
    localparam int NUM_WEIGHTS = 5;
    localparam int NUM_PAIRS   = N * (N - 1) / 2;
    localparam int WEIGHTS_W   = NUM_PAIRS * NUM_WEIGHTS;
    localparam int FIELD_W     = 4;

    // centre bit of the one-hot field is zero coupling.
    localparam logic [NUM_WEIGHTS-1:0] WEIGHT_RST = NUM_WEIGHTS'(1) << (NUM_WEIGHTS / 2);

    localparam logic [31:0] START_ADDR       = 32'h0000_0500;
    localparam logic [31:0] CTR_CUTOFF_ADDR  = 32'h0000_0600;
    localparam logic [31:0] CTR_MAX_ADDR     = 32'h0000_0700;
    localparam logic [31:0] PHASE_ADDR       = 32'h0000_0800;
    localparam logic [31:0] DONE_ADDR        = 32'h0000_0900;
    localparam logic [31:0] WEIGHT_ADDR_BASE = 32'h0000_1000;
    localparam logic [31:0] UNMAPPED_DATA    = 32'hAAAA_AAAA;

    // taps for x^16 + x^14 + x^13 + x^11 in a register that shifts toward bit 0.
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    localparam logic [15:0] LFSR_TAPS = 16'h002D;

    // pairs are numbered in lexicographic order: (0,1), (0,2), ... (N-2,N-1).
    function automatic int pair_index(input int j, input int k);
        int a;
        int b;
        a = (j < k) ? j : k;
        b = (j < k) ? k : j;
        return a * N - a * (a + 1) / 2 + b - a - 1;
    endfunction

endpackage

`default_nettype wire

// File: rtl/ising_cfg_if.sv
// ----------------------------------------
// Configuration levels from the register
// block to the annealing core.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ising_cfg_if;

    logic [ising_pkg::WEIGHTS_W-1:0] weights;
    logic [31:0]                     counter_cutoff;
    logic [31:0]                     counter_max;
    // the core stays in its start state while this active-low level is low.
    logic                            run_n;

    modport regs (
        output weights,
        output counter_cutoff,
        output counter_max,
        output run_n
    );

    modport core (
        input weights,
        input counter_cutoff,
        input counter_max,
        input run_n
    );

endinterface

`default_nettype wire

// File: rtl/ising_anneal_ctrl.sv
// ----------------------------------------
// Run counter, round-robin spin select,
// cutoff phase and noise LFSR.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ising_anneal_ctrl (
    input  wire                      clk,
    input  wire                      run_n,
    input  wire  [31:0]              counter_cutoff,
    input  wire  [31:0]              counter_max,
    output logic [ising_pkg::N-1:0]  update_sel,
    output logic                     noise_phase,
    output logic                     noise_bit,
    output logic                     done
);

    logic [31:0]             counter;
    logic [ising_pkg::N-1:0] sel;
    logic [15:0]             lfsr;
    logic                    active;
    logic                    feedback;

    assign active      = run_n && (counter < counter_max);
    assign noise_phase = counter < counter_cutoff;
    assign noise_bit   = lfsr[0];
    assign update_sel  = active ? sel : '0;
    assign feedback    = ^(lfsr & ising_pkg::LFSR_TAPS);

    always_ff @(posedge clk) begin
        if (!run_n) begin
            counter <= 32'b0;
            sel     <= ising_pkg::N'(1);
            lfsr    <= ising_pkg::LFSR_SEED;
            done    <= 1'b0;
        end else if (active) begin
            counter <= counter + 32'd1;
            sel     <= {sel[ising_pkg::N-2:0], sel[ising_pkg::N-1]};
            if (noise_phase) begin
                lfsr <= {feedback, lfsr[15:1]};
            end
            // done comes up on the same edge that the count reaches the limit.
            done <= (counter + 32'd1 == counter_max);
        end else begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ising_spin_cell.sv
// ----------------------------------------
// One spin with its local field and its
// noise or sign update rule.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ising_spin_cell #(
    parameter int IDX = 0
) (
    input  wire                                                clk,
    input  wire                                                run_n,
    input  wire                                                update,
    input  wire                                                noise_phase,
    input  wire                                                noise_bit,
    input  wire  [ising_pkg::N-1:0]                            phase,
    input  wire  [(ising_pkg::N-1)*ising_pkg::NUM_WEIGHTS-1:0] weights_row,
    output logic                                               spin
);

    logic signed [ising_pkg::FIELD_W-1:0] field;

    // bit b of the one-hot field means coupling b - NUM_WEIGHTS/2.
    function automatic logic signed [ising_pkg::FIELD_W-1:0] coupling(
        input logic [ising_pkg::NUM_WEIGHTS-1:0] w
    );
        logic signed [ising_pkg::FIELD_W-1:0] c;
        c = '0;
        for (int b = 0; b < ising_pkg::NUM_WEIGHTS; b++) begin
            if (w[b]) begin
                c = ising_pkg::FIELD_W'(b - ising_pkg::NUM_WEIGHTS / 2);
            end
        end
        return c;
    endfunction

    // the row skips this cell's own index, so slot m is spin m or m+1.
    always_comb begin
        logic signed [ising_pkg::FIELD_W-1:0] w;
        int                                   slot;
        field = '0;
        for (int k = 0; k < ising_pkg::N; k++) begin
            if (k != IDX) begin
                slot = (k < IDX) ? k : k - 1;
                w = coupling(weights_row[slot*ising_pkg::NUM_WEIGHTS +: ising_pkg::NUM_WEIGHTS]);
                if (phase[k]) begin
                    field = field + w;
                end else begin
                    field = field - w;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!run_n) begin
            spin <= 1'b0;
        end else if (update) begin
            if (noise_phase) begin
                spin <= noise_bit;
            end else if (field > 0) begin
                spin <= 1'b1;
            end else if (field < 0) begin
                spin <= 1'b0;
            end
            // a zero field leaves the spin as it is.
        end
    end

endmodule

`default_nettype wire

// File: rtl/ising_core.sv
// ----------------------------------------
// Annealing core: controller plus N spin
// cells forming the phase vector.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ising_core (
    input  wire                     clk,
    ising_cfg_if.core               cfg,
    output logic [ising_pkg::N-1:0] phase,
    output logic                    done
);

    logic [ising_pkg::N-1:0] update_sel;
    logic                    noise_phase;
    logic                    noise_bit;

    ising_anneal_ctrl ising_anneal_ctrl_i (
        .clk            (clk),
        .run_n          (cfg.run_n),
        .counter_cutoff (cfg.counter_cutoff),
        .counter_max    (cfg.counter_max),
        .update_sel     (update_sel),
        .noise_phase    (noise_phase),
        .noise_bit      (noise_bit),
        .done           (done)
    );

    for (genvar j = 0; j < ising_pkg::N; j++) begin : g_spin
        logic [(ising_pkg::N-1)*ising_pkg::NUM_WEIGHTS-1:0] row;

        // slot m of spin j holds the pair with spin m, or m+1 past j itself.
        for (genvar m = 0; m < ising_pkg::N - 1; m++) begin : g_slot
            assign row[m*ising_pkg::NUM_WEIGHTS +: ising_pkg::NUM_WEIGHTS] =
                cfg.weights[ising_pkg::pair_index(j, (m < j) ? m : m + 1)
                            * ising_pkg::NUM_WEIGHTS +: ising_pkg::NUM_WEIGHTS];
        end

        ising_spin_cell #(
            .IDX (j)
        ) ising_spin_cell_i (
            .clk         (clk),
            .run_n       (cfg.run_n),
            .update      (update_sel[j]),
            .noise_phase (noise_phase),
            .noise_bit   (noise_bit),
            .phase       (phase),
            .weights_row (row),
            .spin        (phase[j])
        );
    end

endmodule

`default_nettype wire

// File: rtl/ising_regs.sv
// ----------------------------------------
// Register block: write decode, config
// registers and the held read port.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ising_regs (
    input  wire                          clk,
    input  wire                          axi_rstn,

    input  wire                          arvalid_q,
    input  wire  [31:0]                  araddr_q,
    input  wire                          rready,
    output logic                         rvalid,
    output logic                         rresp,
    output logic [31:0]                  rdata,

    input  wire                          wready,
    input  wire  [31:0]                  wr_addr,
    input  wire  [31:0]                  wdata,

    input  wire  [ising_pkg::N-1:0]      phase,
    input  wire                          done,

    ising_cfg_if.regs                    cfg
);

    logic [ising_pkg::WEIGHTS_W-1:0] weights;
    logic [31:0]                     counter_cutoff;
    logic [31:0]                     counter_max;
    logic                            run_n;
    logic [31:0]                     rd_value;

    // no error responses are produced.
    assign rresp = 1'b0;

    always_comb begin
        case (araddr_q)
            ising_pkg::PHASE_ADDR: begin
                rd_value = {{(32 - ising_pkg::N){1'b0}}, phase};
            end
            ising_pkg::DONE_ADDR: begin
                rd_value = {31'b0, done};
            end
            default: begin
                rd_value = ising_pkg::UNMAPPED_DATA;
            end
        endcase
    end

    // a request is sampled only when no read is waiting for the host.
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            rvalid <= 1'b0;
            rdata  <= 32'b0;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rdata  <= 32'b0;
        end else if (arvalid_q && !rvalid) begin
            rvalid <= 1'b1;
            rdata  <= rd_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            counter_cutoff <= 32'b0;
            counter_max    <= 32'b0;
            run_n          <= 1'b0;
            weights        <= {ising_pkg::NUM_PAIRS{ising_pkg::WEIGHT_RST}};
        end else if (wready) begin
            if (wr_addr == ising_pkg::CTR_CUTOFF_ADDR) begin
                counter_cutoff <= wdata;
            end
            if (wr_addr == ising_pkg::CTR_MAX_ADDR) begin
                counter_max <= wdata;
            end
            if (wr_addr == ising_pkg::START_ADDR) begin
                run_n <= wdata[0];
            end
            // each pair owns one word, 32 bytes apart.
            for (int i = 0; i < ising_pkg::NUM_PAIRS; i++) begin
                if (wr_addr == ising_pkg::WEIGHT_ADDR_BASE + 32'(32 * i)) begin
                    weights[i*ising_pkg::NUM_WEIGHTS +: ising_pkg::NUM_WEIGHTS] <=
                        wdata[ising_pkg::NUM_WEIGHTS-1:0];
                end
            end
        end
    end

    assign cfg.weights        = weights;
    assign cfg.counter_cutoff = counter_cutoff;
    assign cfg.counter_max    = counter_max;
    assign cfg.run_n          = run_n;

endmodule

`default_nettype wire

// File: rtl/ising_axi.sv
// ----------------------------------------
// Top level: register port beside the
// annealing core it steers.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ising_axi (
    input  wire         clk,
    input  wire         axi_rstn,

    input  wire         arvalid_q,
    input  wire  [31:0] araddr_q,
    input  wire         rready,
    output logic        rvalid,
    output logic        rresp,
    output logic [31:0] rdata,

    input  wire         wready,
    input  wire  [31:0] wr_addr,
    input  wire  [31:0] wdata
);

    logic [ising_pkg::N-1:0] phase;
    logic                    done;

    ising_cfg_if cfg_if ();

    ising_regs ising_regs_i (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .arvalid_q (arvalid_q),
        .araddr_q  (araddr_q),
        .rready    (rready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .wready    (wready),
        .wr_addr   (wr_addr),
        .wdata     (wdata),
        .phase     (phase),
        .done      (done),
        .cfg       (cfg_if.regs)
    );

    ising_core ising_core_i (
        .clk   (clk),
        .cfg   (cfg_if.core),
        .phase (phase),
        .done  (done)
    );

endmodule

`default_nettype wire

// File: dv/ising_axi_tb.sv
// ----------------------------------------
// Testbench for ising_axi that replays the
// golden command file and checks every read.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ising_axi_tb;

    logic        clk;
    logic        axi_rstn;
    logic        arvalid_q;
    logic [31:0] araddr_q;
    logic        rready;
    logic        rvalid;
    logic        rresp;
    logic [31:0] rdata;
    logic        wready;
    logic [31:0] wr_addr;
    logic [31:0] wdata;

    ising_axi ising_axi_i (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .arvalid_q (arvalid_q),
        .araddr_q  (araddr_q),
        .rready    (rready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .wready    (wready),
        .wr_addr   (wr_addr),
        .wdata     (wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input logic [255:0] test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0s %0s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            $display("Test failed");
            $fatal(1, "wrong value in %0s", test_name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Test failed");
        $fatal(1, "timed out while waiting for %0s", what);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        wready  <= 1'b1;
        wr_addr <= addr;
        wdata   <= data;
        @(posedge clk);
        wready <= 1'b0;
    endtask

    // one read with a random rready delay, checking that the response holds.
    task automatic read_word(input logic [255:0] test_name, input logic [31:0] addr,
                             output logic [31:0] value);
        int          waited;
        int          hold;
        logic [31:0] held;
        @(posedge clk);
        arvalid_q <= 1'b1;
        araddr_q  <= addr;
        @(posedge clk);
        arvalid_q <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rvalid && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        if (!rvalid) begin
            timeout_fail("rvalid");
        end
        check_value(test_name, "rresp", 32'd0, 32'(rresp));
        held = rdata;
        hold = $urandom % 4;
        repeat (hold) begin
            @(posedge clk);
            // a second request while the first is pending must be ignored, so it
            // goes to an address whose data differs from the held word.
            arvalid_q <= 1'b1;
            araddr_q  <= (held == ising_pkg::UNMAPPED_DATA) ? ising_pkg::PHASE_ADDR : 32'h0;
            @(negedge clk);
            check_value(test_name, "rvalid hold", 32'd1, 32'(rvalid));
            check_value(test_name, "rdata hold", held, rdata);
        end
        @(posedge clk);
        arvalid_q <= 1'b0;
        rready    <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_value(test_name, "rvalid clear", 32'd0, 32'(rvalid));
        check_value(test_name, "rdata clear", 32'd0, rdata);
        value = held;
    endtask

    task automatic poll_done(input logic [255:0] test_name, input logic [31:0] addr,
                             input logic [31:0] expected);
        logic [31:0] value;
        int          polls;
        polls = 0;
        read_word(test_name, ising_pkg::DONE_ADDR, value);
        while (value[0] !== 1'b1 && polls < 100) begin
            polls++;
            read_word(test_name, ising_pkg::DONE_ADDR, value);
        end
        if (value[0] !== 1'b1) begin
            timeout_fail("done");
        end
        read_word(test_name, addr, value);
        check_value(test_name, "read data", expected, value);
    endtask

    initial begin
        int             fd;
        int             fields;
        int             num_cmds;
        int             seed_val;
        logic [1023:0]  line;
        logic [255:0]   name;
        logic [7:0]     cmd;
        logic [31:0]    addr;
        logic [31:0]    data;
        logic [31:0]    value;

        axi_rstn  = 1'b0;
        arvalid_q = 1'b0;
        araddr_q  = 32'b0;
        rready    = 1'b0;
        wready    = 1'b0;
        wr_addr   = 32'b0;
        wdata     = 32'b0;
        num_cmds  = 0;
        seed_val  = $urandom(25);

        repeat (2) @(posedge clk);
        axi_rstn <= 1'b1;

        fd = $fopen("dv/ising_golden.txt", "r");
        if (fd == 0) begin
            $display("Test failed");
            $fatal(1, "could not open the golden file");
        end

        while (!$feof(fd)) begin
            line   = '0;
            name   = '0;
            fields = 0;
            if ($fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%s %s %h %h", name, cmd, addr, data);
            end
            // lines starting with # describe the columns.
            if (fields > 0 && name != 256'("#")) begin
                if (fields != 4) begin
                    $display("Test failed");
                    $fatal(1, "malformed line in the golden file");
                end
                num_cmds++;
                case (cmd)
                    "W": begin
                        write_word(addr, data);
                    end
                    "R": begin
                        read_word(name, addr, value);
                        check_value(name, "read data", data, value);
                    end
                    "P": begin
                        poll_done(name, addr, data);
                    end
                    default: begin
                        $display("Test failed");
                        $fatal(1, "unknown command in the golden file");
                    end
                endcase
            end
        end
        $fclose(fd);

        if (num_cmds == 0) begin
            $display("Test failed");
            $fatal(1, "the golden file held no commands");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
rtl/ising_pkg.sv
rtl/ising_cfg_if.sv
rtl/ising_anneal_ctrl.sv
rtl/ising_spin_cell.sv
rtl/ising_core.sv
rtl/ising_regs.sv
rtl/ising_axi.sv
dv/ising_axi_tb.sv

// File: Makefile
# Verilator build and run of the Ising accelerator testbench.

TOP := ising_axi_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dv/ising_golden.txt
# columns: test name, command, address (hex), data (hex)
# W writes the data, R reads and expects it, P polls done then reads and expects it
reset_phase     R 00000800 00000000
reset_done      R 00000900 00000000
reset_unmapped  R 00000000 aaaaaaaa
read_hold       R 00000500 aaaaaaaa
read_hold       R 00000700 aaaaaaaa
read_hold       R 00000800 00000000
field_cfg       W 00000600 00000000
field_cfg       W 00000700 00000006
field_cfg       W 00001000 00000001
field_cfg       W 00001020 00000008
field_cfg       W 00001040 00000002
field_start     W 00000500 00000001
field_run       P 00000800 00000005
field_done      R 00000900 00000001
noise_stop      W 00000500 00000000
noise_cfg       W 00000600 00000004
noise_cfg       W 00000700 0000000c
noise_start     W 00000500 00000001
noise_run       P 00000800 00000002
restart_stop    W 00000500 00000000
restart_phase   R 00000800 00000000
restart_done    R 00000900 00000000
restart_cfg     W 00000600 00000000
restart_cfg     W 00000700 00000009
restart_cfg     W 00001000 00000010
restart_cfg     W 00001020 00000002
restart_cfg     W 00001040 00000001
restart_start   W 00000500 00000001
restart_run     P 00000800 00000004
ignored_wr      W 00001010 00000001
ignored_wr      W 00001021 00000010
ignored_wr      W 00001060 00000001
ignored_rd      R 00001010 aaaaaaaa
ignored_rd      R 00001021 aaaaaaaa
ignored_stop    W 00000500 00000000
ignored_start   W 00000500 00000001
ignored_run     P 00000800 00000004
ignored_done    R 00000900 00000001
